// ==== include/exc_defines.svh ====
`ifndef EXC_DEFINES_SVH
`define EXC_DEFINES_SVH

// Trap value width
// Holds the faulting PC or the faulting data address
`define EXC_XLEN 32

// RISC-V exception code width (mcause low bits)
`define EXC_CODE_LEN 5

// Virtual page number inside the trap value
// 4 KiB pages, so the VPN starts at bit 12
`define EXC_VPN_LSB 12
`define EXC_VPN_LEN 20

// Default number of pending exception records
`define EXC_QUEUE_DEPTH 4

`endif

// ==== src/exc_pkg.sv ====
`include "exc_defines.svh"

package exc_pkg;

	// Trap value, PC or data address
	typedef logic [`EXC_XLEN-1:0] xlen_t;

	// Virtual page number sent with a page flush
	typedef logic [`EXC_VPN_LEN-1:0] vpn_t;

	// Exception codes handled by the recovery path
	// Values follow the RISC-V privileged spec
	typedef enum logic [`EXC_CODE_LEN-1:0] {
		I_ADDR_MISALIGNED  = 'd0,
		I_ACCESS_FAULT     = 'd1,
		ILLEGAL_INSTR      = 'd2,
		LD_ADDR_MISALIGNED = 'd4,
		LD_ACCESS_FAULT    = 'd5,
		ST_ADDR_MISALIGNED = 'd6,
		ST_ACCESS_FAULT    = 'd7,
		ENV_CALL_UMODE     = 'd8,
		ENV_CALL_SMODE     = 'd9,
		ENV_CALL_MMODE     = 'd11,
		INSTR_PAGE_FAULT   = 'd12,
		LD_PAGE_FAULT      = 'd13,
		ST_PAGE_FAULT      = 'd15
	} exc_code_e;

	// TLB flush command
	// NO_FLUSH whenever no command is issued
	typedef enum logic [1:0] {
		NO_FLUSH   = 2'd0,
		FLUSH_PAGE = 2'd1,
		FLUSH_ALL  = 2'd2
	} tlb_flush_e;

	// Recovery controller FSM
	// IDLE   wait for a record from the queue
	// ISSUE  one cycle with all cleanup pulses
	// SYNC   L1 D$ to L2 write-back in progress
	// ACK    close the read handshake
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		ISSUE = 2'd1,
		SYNC  = 2'd2,
		ACK   = 2'd3
	} recov_state_e;

endpackage

// ==== src/exc_collector.sv ====
`timescale 1ns/1ps

module exc_collector (
	input  logic                clk_i,
	input  logic                rst_ni,

	// Fetch side exception report
	input  logic                if_exc_valid_i,
	input  exc_pkg::exc_code_e  if_exc_code_i,
	input  exc_pkg::xlen_t      if_exc_tval_i,
	output logic                if_exc_taken_o,

	// Load/store side exception report
	input  logic                ls_exc_valid_i,
	input  exc_pkg::exc_code_e  ls_exc_code_i,
	input  exc_pkg::xlen_t      ls_exc_tval_i,
	output logic                ls_exc_taken_o,

	// Write port toward the queue
	output logic                wr_req_o,
	input  logic                wr_ack_i,
	output exc_pkg::exc_code_e  wr_code_o,
	output exc_pkg::xlen_t      wr_tval_o
);

	import exc_pkg::*;

	// Write handshake phases
	// COL_REQ  req high, waiting for ack
	// COL_WAIT req dropped, waiting for ack to fall
	typedef enum logic [1:0] {
		COL_IDLE = 2'd0,
		COL_REQ  = 2'd1,
		COL_WAIT = 2'd2
	} col_state_e;

	col_state_e state_q;
	logic       pick_if;
	logic       pick_ls;

	// Source selection, fetch side has priority
	// Only in IDLE and only once the previous ack is gone
	assign pick_if = (state_q == COL_IDLE) && !wr_ack_i && if_exc_valid_i;
	assign pick_ls = (state_q == COL_IDLE) && !wr_ack_i && !if_exc_valid_i &&
		ls_exc_valid_i;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q        <= COL_IDLE;
			wr_req_o       <= 1'b0;
			if_exc_taken_o <= 1'b0;
			ls_exc_taken_o <= 1'b0;
		end else begin
			// Taken is a single-cycle pulse
			// Rises together with wr_req
			if_exc_taken_o <= pick_if;
			ls_exc_taken_o <= pick_ls;

			case (state_q)
				COL_IDLE: begin
					if (pick_if || pick_ls) begin
						wr_req_o <= 1'b1;
						state_q  <= COL_REQ;
					end
				end
				COL_REQ: begin
					// Queue has stored the record
					if (wr_ack_i) begin
						wr_req_o <= 1'b0;
						state_q  <= COL_WAIT;
					end
				end
				COL_WAIT: begin
					// Last phase of the handshake
					if (!wr_ack_i) begin
						state_q <= COL_IDLE;
					end
				end
				default: begin
					wr_req_o <= 1'b0;
					state_q  <= COL_IDLE;
				end
			endcase
		end
	end

	// Captured record
	// Source is free once this is loaded, data stays put while req is high
	always_ff @(posedge clk_i) begin
		if (pick_if) begin
			wr_code_o <= if_exc_code_i;
			wr_tval_o <= if_exc_tval_i;
		end else if (pick_ls) begin
			wr_code_o <= ls_exc_code_i;
			wr_tval_o <= ls_exc_tval_i;
		end
	end

endmodule

// ==== src/exc_queue.sv ====
`timescale 1ns/1ps

`include "exc_defines.svh"

module exc_queue #(
	parameter int DEPTH = `EXC_QUEUE_DEPTH
) (
	input  logic                clk_i,
	input  logic                rst_ni,

	// Write side, from the collector
	input  logic                wr_req_i,
	output logic                wr_ack_o,
	input  exc_pkg::exc_code_e  wr_code_i,
	input  exc_pkg::xlen_t      wr_tval_i,

	// Read side, toward the recovery controller
	output logic                rd_req_o,
	input  logic                rd_ack_i,
	output exc_pkg::exc_code_e  rd_code_o,
	output exc_pkg::xlen_t      rd_tval_o
);

	import exc_pkg::*;

	// Pointer needs at least one bit even for a single entry
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Record storage
	exc_code_e        code_mem [DEPTH];
	xlen_t            tval_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             full;
	logic             empty;
	logic             push;
	logic             pop;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full  = (count_q == CNT_W'(DEPTH));
	assign empty = (count_q == '0);

	// Store on a fresh req, held off while full
	assign push = wr_req_i && !wr_ack_o && !full;
	// Head leaves once the controller acks it
	assign pop  = rd_req_o && rd_ack_i;

	// Head record, stable while rd_req is up
	assign rd_code_o = code_mem[rd_ptr_q];
	assign rd_tval_o = tval_mem[rd_ptr_q];

	always_ff @(posedge clk_i) begin
		if (push) begin
			code_mem[wr_ptr_q] <= wr_code_i;
			tval_mem[wr_ptr_q] <= wr_tval_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			wr_ack_o <= 1'b0;
			rd_req_o <= 1'b0;
		end else begin
			// Write handshake
			if (push) begin
				wr_ptr_q <= ptr_inc(wr_ptr_q);
				wr_ack_o <= 1'b1;
			end else if (wr_ack_o && !wr_req_i) begin
				wr_ack_o <= 1'b0;
			end

			// Read handshake
			// New req only after the previous ack has dropped
			if (pop) begin
				rd_ptr_q <= ptr_inc(rd_ptr_q);
				rd_req_o <= 1'b0;
			end else if (!rd_req_o && !rd_ack_i && !empty) begin
				rd_req_o <= 1'b1;
			end

			// Occupancy, both sides may move in one cycle
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

// ==== src/exc_recovery_ctrl.sv ====
`timescale 1ns/1ps

`include "exc_defines.svh"

module exc_recovery_ctrl (
	input  logic                clk_i,
	input  logic                rst_ni,

	// Record from the queue
	input  logic                rd_req_i,
	output logic                rd_ack_o,
	input  exc_pkg::exc_code_e  rd_code_i,
	input  exc_pkg::xlen_t      rd_tval_i,

	// Pipeline control
	output logic                flush_o,
	output logic                stall_o,

	// MSHR clears and abort
	output logic                clr_tlb_mshr_o,
	output logic                clr_dmshr_o,
	output logic                abort_o,

	// TLB flush command
	output exc_pkg::tlb_flush_e tlb_flush_type_o,
	output exc_pkg::vpn_t       tlb_flush_vpn_o,

	// L1 D$ to L2 sync
	output logic                sync_l1dc_l2c_o,
	input  logic                l2c_update_done_i
);

	import exc_pkg::*;

	recov_state_e state_q;
	recov_state_e state_d;

	// Record being serviced
	exc_code_e    code_q;
	xlen_t        tval_q;

	// Decoded action set of the latched code
	logic         dec_clr_tlb;
	logic         dec_clr_dmshr;
	logic         dec_abort;
	logic         dec_page;
	logic         dec_sync;

	always_comb begin
		dec_clr_tlb   = 1'b0;
		dec_clr_dmshr = 1'b0;
		dec_abort     = 1'b0;
		dec_page      = 1'b0;
		dec_sync      = 1'b0;
		case (code_q)
			// Fetch faults, drop pending I-side walks
			I_ADDR_MISALIGNED, I_ACCESS_FAULT: dec_clr_tlb = 1'b1;
			INSTR_PAGE_FAULT: begin
				dec_clr_tlb = 1'b1;
				dec_page    = 1'b1;
			end
			// Load/store faults, drop pending D$ misses
			LD_ADDR_MISALIGNED, LD_ACCESS_FAULT,
			ST_ADDR_MISALIGNED, ST_ACCESS_FAULT: dec_clr_dmshr = 1'b1;
			LD_PAGE_FAULT, ST_PAGE_FAULT: begin
				dec_clr_dmshr = 1'b1;
				dec_page      = 1'b1;
			end
			ILLEGAL_INSTR: dec_abort = 1'b1;
			// Higher privilege ecalls need memory made coherent with L2
			ENV_CALL_SMODE, ENV_CALL_MMODE: dec_sync = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (rd_req_i) begin
					state_d = ISSUE;
				end
			end
			ISSUE: begin
				// Skip the sync when L2 already reports done
				if (dec_sync && !l2c_update_done_i) begin
					state_d = SYNC;
				end else begin
					state_d = ACK;
				end
			end
			SYNC: begin
				if (l2c_update_done_i) begin
					state_d = ACK;
				end
			end
			ACK: begin
				// Queue has dropped req, close the handshake
				if (!rd_req_i) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Latch on first sight of req
	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && rd_req_i) begin
			code_q <= rd_code_i;
			tval_q <= rd_tval_i;
		end
	end

	// All pulses come from the single ISSUE cycle
	assign flush_o        = (state_q == ISSUE);
	assign clr_tlb_mshr_o = (state_q == ISSUE) && dec_clr_tlb;
	assign clr_dmshr_o    = (state_q == ISSUE) && dec_clr_dmshr;
	assign abort_o        = (state_q == ISSUE) && dec_abort;

	always_comb begin
		tlb_flush_type_o = NO_FLUSH;
		tlb_flush_vpn_o  = '0;
		if (state_q == ISSUE) begin
			if (dec_page) begin
				// Only the faulting page is dropped
				tlb_flush_type_o = FLUSH_PAGE;
				tlb_flush_vpn_o  = tval_q[`EXC_VPN_LSB +: `EXC_VPN_LEN];
			end else begin
				tlb_flush_type_o = FLUSH_ALL;
			end
		end
	end

	// Levels
	// Stall starts with the first sight of req in IDLE
	assign sync_l1dc_l2c_o = (state_q == SYNC);
	assign stall_o         = (state_q != IDLE) || rd_req_i;
	assign rd_ack_o        = (state_q == ACK);

endmodule

// ==== src/exc_ctrl_top.sv ====
`timescale 1ns/1ps

module exc_ctrl_top (
	input  logic                clk_i,
	input  logic                rst_ni,

	// Fetch side source
	input  logic                if_exc_valid_i,
	input  exc_pkg::exc_code_e  if_exc_code_i,
	input  exc_pkg::xlen_t      if_exc_tval_i,
	output logic                if_exc_taken_o,

	// Load/store side source
	input  logic                ls_exc_valid_i,
	input  exc_pkg::exc_code_e  ls_exc_code_i,
	input  exc_pkg::xlen_t      ls_exc_tval_i,
	output logic                ls_exc_taken_o,

	// Recovery actions
	output logic                flush_o,
	output logic                stall_o,
	output logic                clr_tlb_mshr_o,
	output logic                clr_dmshr_o,
	output logic                abort_o,
	output exc_pkg::tlb_flush_e tlb_flush_type_o,
	output exc_pkg::vpn_t       tlb_flush_vpn_o,
	output logic                sync_l1dc_l2c_o,
	input  logic                l2c_update_done_i
);

	import exc_pkg::*;

	// Collector to queue
	logic      exc_wr_req;
	logic      exc_wr_ack;
	exc_code_e exc_wr_code;
	xlen_t     exc_wr_tval;

	// Queue to controller
	logic      exc_rd_req;
	logic      exc_rd_ack;
	exc_code_e exc_rd_code;
	xlen_t     exc_rd_tval;

	exc_collector exc_collector_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.if_exc_valid_i (if_exc_valid_i),
		.if_exc_code_i  (if_exc_code_i),
		.if_exc_tval_i  (if_exc_tval_i),
		.if_exc_taken_o (if_exc_taken_o),
		.ls_exc_valid_i (ls_exc_valid_i),
		.ls_exc_code_i  (ls_exc_code_i),
		.ls_exc_tval_i  (ls_exc_tval_i),
		.ls_exc_taken_o (ls_exc_taken_o),
		.wr_req_o       (exc_wr_req),
		.wr_ack_i       (exc_wr_ack),
		.wr_code_o      (exc_wr_code),
		.wr_tval_o      (exc_wr_tval)
	);

	// Keeps records in arrival order
	exc_queue exc_queue_i (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.wr_req_i  (exc_wr_req),
		.wr_ack_o  (exc_wr_ack),
		.wr_code_i (exc_wr_code),
		.wr_tval_i (exc_wr_tval),
		.rd_req_o  (exc_rd_req),
		.rd_ack_i  (exc_rd_ack),
		.rd_code_o (exc_rd_code),
		.rd_tval_o (exc_rd_tval)
	);

	exc_recovery_ctrl exc_recovery_ctrl_i (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.rd_req_i          (exc_rd_req),
		.rd_ack_o          (exc_rd_ack),
		.rd_code_i         (exc_rd_code),
		.rd_tval_i         (exc_rd_tval),
		.flush_o           (flush_o),
		.stall_o           (stall_o),
		.clr_tlb_mshr_o    (clr_tlb_mshr_o),
		.clr_dmshr_o       (clr_dmshr_o),
		.abort_o           (abort_o),
		.tlb_flush_type_o  (tlb_flush_type_o),
		.tlb_flush_vpn_o   (tlb_flush_vpn_o),
		.sync_l1dc_l2c_o   (sync_l1dc_l2c_o),
		.l2c_update_done_i (l2c_update_done_i)
	);

endmodule

// ==== verif/tb_exc_ctrl.sv ====
`timescale 1ns/1ps

`include "exc_defines.svh"

module tb_exc_ctrl;

	import exc_pkg::*;

	localparam int WAIT_LIMIT = 500;
	localparam int LOG_SIZE   = 64;

	logic       clk_i;
	logic       rst_ni;
	logic       if_exc_valid;
	exc_code_e  if_exc_code;
	xlen_t      if_exc_tval;
	logic       if_exc_taken;
	logic       ls_exc_valid;
	exc_code_e  ls_exc_code;
	xlen_t      ls_exc_tval;
	logic       ls_exc_taken;
	logic       flush;
	logic       stall;
	logic       clr_tlb_mshr;
	logic       clr_dmshr;
	logic       abort;
	tlb_flush_e tlb_flush_type;
	vpn_t       tlb_flush_vpn;
	logic       sync_l1dc_l2c;
	logic       l2c_update_done;

	// One entry per ISSUE cycle
	tlb_flush_e log_type  [LOG_SIZE];
	vpn_t       log_vpn   [LOG_SIZE];
	logic       log_tlb   [LOG_SIZE];
	logic       log_dmshr [LOG_SIZE];
	logic       log_abort [LOG_SIZE];
	int         log_n;
	logic       sync_seen;
	int         checks;
	int         errors;

	exc_ctrl_top exc_ctrl_top_i (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.if_exc_valid_i    (if_exc_valid),
		.if_exc_code_i     (if_exc_code),
		.if_exc_tval_i     (if_exc_tval),
		.if_exc_taken_o    (if_exc_taken),
		.ls_exc_valid_i    (ls_exc_valid),
		.ls_exc_code_i     (ls_exc_code),
		.ls_exc_tval_i     (ls_exc_tval),
		.ls_exc_taken_o    (ls_exc_taken),
		.flush_o           (flush),
		.stall_o           (stall),
		.clr_tlb_mshr_o    (clr_tlb_mshr),
		.clr_dmshr_o       (clr_dmshr),
		.abort_o           (abort),
		.tlb_flush_type_o  (tlb_flush_type),
		.tlb_flush_vpn_o   (tlb_flush_vpn),
		.sync_l1dc_l2c_o   (sync_l1dc_l2c),
		.l2c_update_done_i (l2c_update_done)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// Outputs settle mid-cycle, so sample on the falling edge
	always @(negedge clk_i) begin
		if (flush && log_n < LOG_SIZE) begin
			log_type[log_n]  = tlb_flush_type;
			log_vpn[log_n]   = tlb_flush_vpn;
			log_tlb[log_n]   = clr_tlb_mshr;
			log_dmshr[log_n] = clr_dmshr;
			log_abort[log_n] = abort;
			log_n++;
		end
		if (sync_l1dc_l2c) begin
			sync_seen = 1'b1;
		end
	end

	// Side actions only ever ride on a flush
	always @(negedge clk_i) begin
		if (rst_ni && !flush && (clr_tlb_mshr || clr_dmshr || abort ||
			tlb_flush_type != NO_FLUSH)) begin
			errors++;
			$display("[FAIL] %0t action output active outside a flush", $time);
		end
	end

	task automatic check_code(string what, exc_code_e got, exc_code_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %s, expected %s", $time, what, got.name(),
				exp.name());
		end
	endtask

	task automatic check_flush(string what, tlb_flush_e got, tlb_flush_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %s, expected %s", $time, what, got.name(),
				exp.name());
		end
	endtask

	task automatic check_vpn(string what, vpn_t got, vpn_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(string what, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic stop_on_timeout(string what);
		$display("Timeout while waiting for %s at %0t", what, $time);
		$display("sim failed");
		$finish;
	endtask

	// Decode rules, one per action
	function automatic logic exp_clr_tlb(exc_code_e code);
		case (code)
			I_ADDR_MISALIGNED, I_ACCESS_FAULT, INSTR_PAGE_FAULT: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic exp_clr_dmshr(exc_code_e code);
		case (code)
			LD_ADDR_MISALIGNED, LD_ACCESS_FAULT, ST_ADDR_MISALIGNED, ST_ACCESS_FAULT,
			LD_PAGE_FAULT, ST_PAGE_FAULT: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic is_page_fault(exc_code_e code);
		return code == INSTR_PAGE_FAULT || code == LD_PAGE_FAULT ||
			code == ST_PAGE_FAULT;
	endfunction

	// Class representative of a submitted code
	function automatic exc_code_e code_class(exc_code_e code);
		if (code == ILLEGAL_INSTR) return ILLEGAL_INSTR;
		if (exp_clr_tlb(code)) return is_page_fault(code) ? INSTR_PAGE_FAULT : I_ACCESS_FAULT;
		if (exp_clr_dmshr(code)) return is_page_fault(code) ? LD_PAGE_FAULT : LD_ACCESS_FAULT;
		return ENV_CALL_UMODE;
	endfunction

	// Class as seen from the logged pulse set
	function automatic exc_code_e seen_class(int idx);
		if (log_abort[idx]) return ILLEGAL_INSTR;
		if (log_tlb[idx]) return (log_type[idx] == FLUSH_PAGE) ? INSTR_PAGE_FAULT : I_ACCESS_FAULT;
		if (log_dmshr[idx]) return (log_type[idx] == FLUSH_PAGE) ? LD_PAGE_FAULT : LD_ACCESS_FAULT;
		return ENV_CALL_UMODE;
	endfunction

	task automatic check_entry(int idx, exc_code_e code, xlen_t tval);
		vpn_t exp_vpn;
		exp_vpn = is_page_fault(code) ? tval[`EXC_VPN_LSB +: `EXC_VPN_LEN] : '0;
		check_code($sformatf("entry %0d class", idx), seen_class(idx), code_class(code));
		check_bit($sformatf("entry %0d clr_tlb_mshr", idx), log_tlb[idx], exp_clr_tlb(code));
		check_bit($sformatf("entry %0d clr_dmshr", idx), log_dmshr[idx], exp_clr_dmshr(code));
		check_bit($sformatf("entry %0d abort", idx), log_abort[idx], code == ILLEGAL_INSTR);
		check_flush($sformatf("entry %0d flush type", idx), log_type[idx],
			is_page_fault(code) ? FLUSH_PAGE : FLUSH_ALL);
		check_vpn($sformatf("entry %0d vpn", idx), log_vpn[idx], exp_vpn);
	endtask

	// Hold the report until the matching taken pulse
	task automatic send_report(logic ls, exc_code_e code, xlen_t tval);
		int   cycles;
		logic got;
		@(negedge clk_i);
		if (ls) begin
			ls_exc_valid = 1'b1;
			ls_exc_code  = code;
			ls_exc_tval  = tval;
		end else begin
			if_exc_valid = 1'b1;
			if_exc_code  = code;
			if_exc_tval  = tval;
		end
		got    = 1'b0;
		cycles = 0;
		while (!got && cycles < WAIT_LIMIT) begin
			@(negedge clk_i);
			got = ls ? ls_exc_taken : if_exc_taken;
			cycles++;
		end
		if (!got) stop_on_timeout(ls ? "load/store taken" : "fetch taken");
		if (ls) ls_exc_valid = 1'b0;
		else if_exc_valid = 1'b0;
	endtask

	task automatic wait_log(int n);
		int cycles;
		cycles = 0;
		while (log_n < n && cycles < WAIT_LIMIT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (log_n < n) stop_on_timeout("flush pulse");
	endtask

	task automatic wait_sync(logic level);
		int cycles;
		cycles = 0;
		while (sync_l1dc_l2c !== level && cycles < WAIT_LIMIT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (sync_l1dc_l2c !== level) stop_on_timeout("cache sync level");
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (stall !== 1'b0 && cycles < WAIT_LIMIT) begin
			@(negedge clk_i);
			cycles++;
		end
		if (stall !== 1'b0) stop_on_timeout("stall release");
	endtask

	// Single report through the whole path
	task automatic run_report(logic ls, exc_code_e code, xlen_t tval);
		int idx;
		idx = log_n;
		send_report(ls, code, tval);
		wait_log(idx + 1);
		wait_idle();
		check_entry(idx, code, tval);
		check_bit("one flush per report", log_n == idx + 1, 1'b1);
	endtask

	task automatic report_test(string name, int errs_before);
		$display("%s: %0d errors", name, errors - errs_before);
	endtask

	task automatic test_reset_state();
		int e;
		e = errors;
		check_bit("flush after reset", flush, 1'b0);
		check_bit("stall after reset", stall, 1'b0);
		check_bit("clr_tlb_mshr after reset", clr_tlb_mshr, 1'b0);
		check_bit("clr_dmshr after reset", clr_dmshr, 1'b0);
		check_bit("abort after reset", abort, 1'b0);
		check_bit("sync after reset", sync_l1dc_l2c, 1'b0);
		check_bit("fetch taken after reset", if_exc_taken, 1'b0);
		check_bit("load/store taken after reset", ls_exc_taken, 1'b0);
		check_flush("flush type after reset", tlb_flush_type, NO_FLUSH);
		report_test("reset state", e);
	endtask

	task automatic test_code_classes();
		int e;
		e = errors;
		run_report(1'b0, I_ACCESS_FAULT, $urandom());
		run_report(1'b1, LD_ACCESS_FAULT, $urandom());
		run_report(1'b1, ST_ACCESS_FAULT, $urandom());
		run_report(1'b0, ILLEGAL_INSTR, $urandom());
		run_report(1'b0, ENV_CALL_UMODE, $urandom());
		report_test("code classes", e);
	endtask

	task automatic test_page_flush();
		int e;
		e = errors;
		run_report(1'b0, INSTR_PAGE_FAULT, $urandom());
		run_report(1'b1, LD_PAGE_FAULT, $urandom());
		run_report(1'b1, ST_PAGE_FAULT, $urandom());
		run_report(1'b0, I_ADDR_MISALIGNED, $urandom());
		run_report(1'b1, LD_ADDR_MISALIGNED, $urandom());
		run_report(1'b1, ST_ADDR_MISALIGNED, $urandom());
		report_test("tlb page flush", e);
	endtask

	task automatic test_cache_sync();
		int    e;
		int    idx;
		xlen_t tval;
		e    = errors;
		idx  = log_n;
		tval = $urandom();
		l2c_update_done = 1'b0;
		send_report(1'b0, ENV_CALL_MMODE, tval);
		wait_sync(1'b1);
		// L2 still busy, sync and stall must hold
		repeat (12) begin
			@(negedge clk_i);
			check_bit("sync held", sync_l1dc_l2c, 1'b1);
			check_bit("stall held during sync", stall, 1'b1);
		end
		l2c_update_done = 1'b1;
		wait_sync(1'b0);
		wait_idle();
		check_entry(idx, ENV_CALL_MMODE, tval);
		// Done already high, no sync expected
		sync_seen = 1'b0;
		run_report(1'b0, ENV_CALL_SMODE, $urandom());
		check_bit("no sync with done high", sync_seen, 1'b0);
		report_test("cache sync", e);
	endtask

	task automatic test_priority();
		int    e;
		int    idx;
		xlen_t tval_if;
		xlen_t tval_ls;
		e       = errors;
		idx     = log_n;
		tval_if = $urandom();
		tval_ls = $urandom();
		fork
			send_report(1'b0, I_ACCESS_FAULT, tval_if);
			send_report(1'b1, LD_PAGE_FAULT, tval_ls);
		join
		wait_log(idx + 2);
		wait_idle();
		check_entry(idx, I_ACCESS_FAULT, tval_if);
		check_entry(idx + 1, LD_PAGE_FAULT, tval_ls);
		report_test("fetch priority", e);
	endtask

	task automatic test_back_pressure();
		exc_code_e codes [6];
		xlen_t     tvals [6];
		logic      sides [6];
		xlen_t     first_tval;
		int        e;
		int        idx;
		int        sent;
		e     = errors;
		idx   = log_n;
		sent  = 0;
		codes[0] = INSTR_PAGE_FAULT;
		codes[1] = LD_PAGE_FAULT;
		codes[2] = ST_PAGE_FAULT;
		codes[3] = ILLEGAL_INSTR;
		codes[4] = LD_ACCESS_FAULT;
		codes[5] = INSTR_PAGE_FAULT;
		for (int i = 0; i < 6; i++) begin
			tvals[i] = $urandom();
			sides[i] = (codes[i] == LD_PAGE_FAULT || codes[i] == ST_PAGE_FAULT ||
				codes[i] == LD_ACCESS_FAULT);
		end
		first_tval      = $urandom();
		l2c_update_done = 1'b0;
		send_report(1'b0, ENV_CALL_MMODE, first_tval);
		wait_sync(1'b1);
		fork
			begin
				for (int i = 0; i < 6; i++) begin
					send_report(sides[i], codes[i], tvals[i]);
					sent++;
				end
			end
			begin
				// Queue fills while the sync blocks the head
				repeat (40) @(negedge clk_i);
				check_bit("sources held by back-pressure", sent < 6, 1'b1);
				l2c_update_done = 1'b1;
			end
		join
		wait_log(idx + 7);
		wait_idle();
		check_entry(idx, ENV_CALL_MMODE, first_tval);
		for (int i = 0; i < 6; i++) begin
			check_entry(idx + 1 + i, codes[i], tvals[i]);
		end
		check_bit("seven records logged once", log_n == idx + 7, 1'b1);
		report_test("back-pressure order", e);
	endtask

	initial begin
		void'($urandom(51572));
		checks          = 0;
		errors          = 0;
		log_n           = 0;
		sync_seen       = 1'b0;
		rst_ni          = 1'b0;
		if_exc_valid    = 1'b0;
		if_exc_code     = I_ADDR_MISALIGNED;
		if_exc_tval     = '0;
		ls_exc_valid    = 1'b0;
		ls_exc_code     = I_ADDR_MISALIGNED;
		ls_exc_tval     = '0;
		l2c_update_done = 1'b1;
		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		rst_ni = 1'b1;
		@(negedge clk_i);

		test_reset_state();
		test_code_classes();
		test_page_flush();
		test_cache_sync();
		test_priority();
		test_back_pressure();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+include
src/exc_pkg.sv
src/exc_collector.sv
src/exc_queue.sv
src/exc_recovery_ctrl.sv
src/exc_ctrl_top.sv
verif/tb_exc_ctrl.sv

// ==== Bender.yml ====
package:
  name: exc_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/exc_pkg.sv
      - src/exc_collector.sv
      - src/exc_queue.sv
      - src/exc_recovery_ctrl.sv
      - src/exc_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_exc_ctrl.sv
